/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    typedef logic [4:0] reg_addr_t;
    typedef logic [31:0] word_t;

    // primary opcodes the core decodes
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_t;

    // SPECIAL function field, also used as the ALU operation code
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic [4:0] sa;
        funct_t    funct;
    } r_view_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        logic [15:0] imm16;
    } i_view_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] target26;
    } j_view_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_t;

endpackage

`default_nettype wire

/* src/mips_cpu_pkg.sv */
`default_nettype none

package mips_cpu_pkg;

    typedef enum logic {
        RUN    = 1'b0,
        HALTED = 1'b1
    } cpu_state_t;

    typedef enum logic {
        WB_ALU  = 1'b0,
        WB_LOAD = 1'b1
    } wb_sel_t;

    // jump target kinds
    localparam logic [1:0] JUMP_BRANCH = 2'd0;
    localparam logic [1:0] JUMP_INDEX  = 2'd1;
    localparam logic [1:0] JUMP_REG    = 2'd2;

    localparam logic [31:0] RESET_VECTOR_DEFAULT = 32'h20;

endpackage

`default_nettype wire

/* src/control_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module control_fsm (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    clk_enable,
    input  mips_isa_pkg::instr_t    instr,
    input  logic                    pc_is_zero,
    input  logic                    rs_equal_rt,
    output logic                    active,
    output logic                    step,
    output logic                    reg_we,
    output logic                    data_read,
    output logic                    data_write,
    output mips_isa_pkg::reg_addr_t reg_waddr,
    output mips_cpu_pkg::wb_sel_t   wb_sel,
    output mips_isa_pkg::funct_t    alu_op,
    output logic                    use_imm,
    output logic                    jump_req,
    output logic [1:0]              jump_kind
);
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;

    cpu_state_t state;
    logic executing;
    logic writes_reg;
    logic is_lw;
    logic is_sw;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= RUN;
            active <= 1'b1;
        end else if (clk_enable && state == RUN && pc_is_zero) begin
            state  <= HALTED;
            active <= 1'b0;
        end
    end

    // nothing at address 0 ever runs
    assign executing  = !reset && state == RUN && !pc_is_zero;
    assign step       = executing && clk_enable;
    assign is_lw      = instr.i.opcode == OP_LW;
    assign is_sw      = instr.i.opcode == OP_SW;
    assign data_read  = step && is_lw;
    assign data_write = step && is_sw;
    assign reg_we     = step && writes_reg;

    always_comb begin
        writes_reg = 1'b0;
        reg_waddr  = instr.i.rt;
        wb_sel     = WB_ALU;
        alu_op     = FN_ADDU;
        use_imm    = 1'b0;
        jump_req   = 1'b0;
        jump_kind  = JUMP_BRANCH;
        case (instr.i.opcode)
            OP_SPECIAL: begin
                reg_waddr = instr.r.rd;
                alu_op    = instr.r.funct;
                if (instr.r.funct == FN_JR) begin
                    jump_req  = 1'b1;
                    jump_kind = JUMP_REG;
                end else begin
                    writes_reg = instr.r.funct inside {FN_SLL, FN_SRL, FN_SRA, FN_ADDU,
                        FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
                end
            end
            OP_J: begin
                jump_req  = 1'b1;
                jump_kind = JUMP_INDEX;
            end
            OP_BEQ: jump_req = rs_equal_rt;
            OP_BNE: jump_req = !rs_equal_rt;
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                writes_reg = 1'b1;
                use_imm    = 1'b1;
                case (instr.i.opcode)
                    OP_SLTI: alu_op = FN_SLT;
                    OP_ANDI: alu_op = FN_AND;
                    OP_XORI: alu_op = FN_XOR;
                    // lui ors the shifted immediate onto a zero operand
                    OP_ORI, OP_LUI: alu_op = FN_OR;
                    default: alu_op = FN_ADDU;
                endcase
            end
            OP_LW: begin
                writes_reg = 1'b1;
                wb_sel     = WB_LOAD;
            end
            default: writes_reg = 1'b0;
        endcase
    end

    // dropped instructions would otherwise retire as nops
    a_known_opcode: assert property (
        @(posedge clk) step |-> instr.i.opcode inside {OP_SPECIAL, OP_J, OP_BEQ, OP_BNE,
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW}
    );

endmodule

`default_nettype wire

/* src/pc_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_counter #(
    parameter logic [31:0] RESET_VECTOR = mips_cpu_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                step,
    input  logic                jump_req,
    input  logic [1:0]          jump_kind,
    input  logic [15:0]         imm16,
    input  logic [25:0]         target26,
    input  mips_isa_pkg::word_t rs_value,
    output mips_isa_pkg::word_t pc,
    output logic                pc_is_zero
);
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;

    word_t pc_plus4;
    word_t next_target;
    word_t jump_target;
    logic  pending;

    assign pc_plus4   = pc + 32'd4;
    assign pc_is_zero = pc == '0;

    always_comb begin
        case (jump_kind)
            JUMP_BRANCH: next_target = pc_plus4 + {{14{imm16[15]}}, imm16, 2'b00};
            JUMP_INDEX:  next_target = {pc[31:28], target26, 2'b00};
            default:     next_target = rs_value;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= RESET_VECTOR;
            pending <= 1'b0;
        end else if (step) begin
            pc      <= pending ? jump_target : pc_plus4;
            pending <= jump_req;
        end
    end

    // target waits here for one delay slot
    always_ff @(posedge clk) begin
        if (step && jump_req) begin
            jump_target <= next_target;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    we,
    input  mips_isa_pkg::reg_addr_t waddr,
    input  mips_isa_pkg::reg_addr_t raddr_a,
    input  mips_isa_pkg::reg_addr_t raddr_b,
    input  mips_isa_pkg::word_t     wdata,
    output mips_isa_pkg::word_t     rdata_a,
    output mips_isa_pkg::word_t     rdata_b,
    output mips_isa_pkg::word_t     v0
);
    import mips_isa_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // $zero keeps its reset value
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign v0      = regs[2];

    a_zero_kept: assert property (
        @(posedge clk) disable iff (reset) (we && waddr == '0) |=> regs[0] == '0
    );

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  mips_isa_pkg::word_t   rs_value,
    input  mips_isa_pkg::word_t   rt_value,
    input  mips_isa_pkg::instr_t  instr,
    input  mips_isa_pkg::funct_t  alu_op,
    input  logic                  use_imm,
    input  mips_cpu_pkg::wb_sel_t wb_sel,
    input  mips_isa_pkg::word_t   load_data,
    output mips_isa_pkg::word_t   data_address,
    output mips_isa_pkg::word_t   wb_data,
    output logic                  rs_equal_rt
);
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;

    word_t imm_sext;
    word_t imm_zext;
    word_t a_operand;
    word_t b_operand;
    word_t alu_result;
    logic  is_lui;

    assign imm_sext = {{16{instr.i.imm16[15]}}, instr.i.imm16};
    assign imm_zext = {16'h0000, instr.i.imm16};
    assign is_lui   = instr.i.opcode == OP_LUI;

    assign a_operand = is_lui ? '0 : rs_value;

    always_comb begin
        if (!use_imm) begin
            b_operand = rt_value;
        end else if (is_lui) begin
            b_operand = {instr.i.imm16, 16'h0000};
        end else if (alu_op inside {FN_AND, FN_OR, FN_XOR}) begin
            // logic immediates are zero-extended
            b_operand = imm_zext;
        end else begin
            b_operand = imm_sext;
        end
    end

    always_comb begin
        case (alu_op)
            FN_ADDU: alu_result = a_operand + b_operand;
            FN_SUBU: alu_result = a_operand - b_operand;
            FN_AND:  alu_result = a_operand & b_operand;
            FN_OR:   alu_result = a_operand | b_operand;
            FN_XOR:  alu_result = a_operand ^ b_operand;
            FN_SLT:  alu_result = {31'd0, $signed(a_operand) < $signed(b_operand)};
            FN_SLTU: alu_result = {31'd0, a_operand < b_operand};
            // shifts act on rt by the sa field
            FN_SLL:  alu_result = b_operand << instr.r.sa;
            FN_SRL:  alu_result = b_operand >> instr.r.sa;
            FN_SRA:  alu_result = $signed(b_operand) >>> instr.r.sa;
            default: alu_result = '0;
        endcase
    end

    assign wb_data      = (wb_sel == WB_LOAD) ? load_data : alu_result;
    assign data_address = rs_value + imm_sext;
    assign rs_equal_rt  = rs_value == rt_value;

endmodule

`default_nettype wire

/* src/mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = mips_cpu_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        clk_enable,
    input  logic [31:0] instr_readdata,
    input  logic [31:0] data_readdata,
    output logic        active,
    output logic [31:0] register_v0,
    output logic [31:0] instr_address,
    output logic [31:0] data_address,
    output logic [31:0] data_writedata,
    output logic        data_write,
    output logic        data_read
);
    import mips_isa_pkg::*;
    import mips_cpu_pkg::*;

    instr_t    instr;
    word_t     pc;
    word_t     rs_value;
    word_t     rt_value;
    word_t     wb_data;
    reg_addr_t reg_waddr;
    funct_t    alu_op;
    wb_sel_t   wb_sel;
    logic      step;
    logic      reg_we;
    logic      use_imm;
    logic      jump_req;
    logic [1:0] jump_kind;
    logic      pc_is_zero;
    logic      rs_equal_rt;

    assign instr          = instr_readdata;
    assign instr_address  = pc;
    assign data_writedata = rt_value;

    control_fsm u_control (
        .clk(clk), .reset(reset), .clk_enable(clk_enable), .instr(instr),
        .pc_is_zero(pc_is_zero), .rs_equal_rt(rs_equal_rt), .active(active),
        .step(step), .reg_we(reg_we), .data_read(data_read), .data_write(data_write),
        .reg_waddr(reg_waddr), .wb_sel(wb_sel), .alu_op(alu_op), .use_imm(use_imm),
        .jump_req(jump_req), .jump_kind(jump_kind)
    );

    pc_counter #(.RESET_VECTOR(RESET_VECTOR)) u_pc (
        .clk(clk), .reset(reset), .step(step), .jump_req(jump_req),
        .jump_kind(jump_kind), .imm16(instr.i.imm16), .target26(instr.j.target26),
        .rs_value(rs_value), .pc(pc), .pc_is_zero(pc_is_zero)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset), .we(reg_we), .waddr(reg_waddr),
        .raddr_a(instr.r.rs), .raddr_b(instr.r.rt), .wdata(wb_data),
        .rdata_a(rs_value), .rdata_b(rt_value), .v0(register_v0)
    );

    exec_unit u_exec (
        .rs_value(rs_value), .rt_value(rt_value), .instr(instr), .alu_op(alu_op),
        .use_imm(use_imm), .wb_sel(wb_sel), .load_data(data_readdata),
        .data_address(data_address), .wb_data(wb_data), .rs_equal_rt(rs_equal_rt)
    );

endmodule

`default_nettype wire

/* tb/tb_mips_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu;

    localparam int CLK_PERIOD = 4;
    // instruction count of all programs, reset and halt cycles per run, margin for stalls
    localparam int PROGRAM_INSTRS = 189;
    localparam int RUN_COUNT = 20;
    localparam int RUN_OVERHEAD = 8;
    localparam int MARGIN = 4;
    localparam int WATCHDOG_NS =
        (PROGRAM_INSTRS + RUN_COUNT * RUN_OVERHEAD) * CLK_PERIOD * MARGIN;

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_J = 6'h02;
    localparam logic [5:0] OPC_BEQ = 6'h04;
    localparam logic [5:0] OPC_BNE = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_SLTI = 6'h0a;
    localparam logic [5:0] OPC_ANDI = 6'h0c;
    localparam logic [5:0] OPC_ORI = 6'h0d;
    localparam logic [5:0] OPC_XORI = 6'h0e;
    localparam logic [5:0] OPC_LUI = 6'h0f;
    localparam logic [5:0] OPC_LW = 6'h23;
    localparam logic [5:0] OPC_SW = 6'h2b;

    localparam logic [5:0] FN_SLL = 6'h00;
    localparam logic [5:0] FN_SRL = 6'h02;
    localparam logic [5:0] FN_SRA = 6'h03;
    localparam logic [5:0] FN_JR = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26;
    localparam logic [5:0] FN_SLT = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam logic [4:0] R_ZERO = 5'd0;
    localparam logic [4:0] R_V0 = 5'd2;
    localparam logic [4:0] R_A = 5'd8;
    localparam logic [4:0] R_B = 5'd9;
    localparam logic [4:0] R_C = 5'd10;

    logic        clk;
    logic        reset;
    logic        clk_enable;
    logic [31:0] instr_readdata;
    logic [31:0] data_readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] instr_address;
    logic [31:0] data_address;
    logic [31:0] data_writedata;
    logic        data_write;
    logic        data_read;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] prog [$];
    logic [31:0] lfsr_state = 32'h3332;
    logic [31:0] branch_expect;
    int          checks = 0;
    int          errors = 0;

    // written only by the bus monitor
    int          write_count = 0;
    logic [31:0] last_write_addr;
    logic [31:0] last_write_data;
    int          read_count = 0;
    logic [31:0] last_read_addr;
    int          stall_cycles = 0;
    int          monitor_checks = 0;
    int          monitor_errors = 0;
    logic [31:0] prev_pc;
    logic        prev_en = 1'b0;
    logic        prev_reset = 1'b1;

    mips_cpu #(.RESET_VECTOR(32'h20)) DUT (
        .clk(clk), .reset(reset), .clk_enable(clk_enable),
        .instr_readdata(instr_readdata), .data_readdata(data_readdata),
        .active(active), .register_v0(register_v0), .instr_address(instr_address),
        .data_address(data_address), .data_writedata(data_writedata),
        .data_write(data_write), .data_read(data_read)
    );

    assign instr_readdata = imem[instr_address[7:2]];
    assign data_readdata  = dmem[data_address[7:2]];

    always @(posedge clk) begin
        if (data_write) begin
            dmem[data_address[7:2]] <= data_writedata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the DUT halted");
        $display("Test failed");
        $finish;
    end

    // clk_enable seen here governs the next rising edge
    always @(negedge clk) begin
        if (data_write) begin
            write_count = write_count + 1;
            last_write_addr = data_address;
            last_write_data = data_writedata;
        end
        if (data_read) begin
            read_count = read_count + 1;
            last_read_addr = data_address;
        end
        if (!clk_enable) begin
            monitor_checks = monitor_checks + 1;
            assert (!data_write && !data_read) else begin
                monitor_errors = monitor_errors + 1;
                $display("** Error at %0d ns: memory strobe high while stalled", $time);
            end
        end
        if (!prev_reset && !prev_en) begin
            stall_cycles = stall_cycles + 1;
            monitor_checks = monitor_checks + 1;
            assert (instr_address == prev_pc) else begin
                monitor_errors = monitor_errors + 1;
                $display("** Error at %0d ns: instr_address moved from %h to %h in a stall",
                    $time, prev_pc, instr_address);
            end
        end
        prev_pc = instr_address;
        prev_en = clk_enable;
        prev_reset = reset;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        logic        feedback;
        value = 32'h0;
        for (int k = 0; k < n; k++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [4:0] sa,
                                           input logic [5:0] funct);
        return {OPC_SPECIAL, rs, rt, rd, sa, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] alu_instr(input int op, input logic [15:0] imm,
                                              input logic [4:0] sa);
        case (op)
            0: return i_type(OPC_ADDIU, R_A, R_C, imm);
            1: return i_type(OPC_LUI, R_ZERO, R_C, imm);
            2: return i_type(OPC_ORI, R_A, R_C, imm);
            3: return i_type(OPC_ANDI, R_A, R_C, imm);
            4: return i_type(OPC_XORI, R_A, R_C, imm);
            5: return i_type(OPC_SLTI, R_A, R_C, imm);
            6: return r_type(R_A, R_B, R_C, 5'd0, FN_ADDU);
            7: return r_type(R_A, R_B, R_C, 5'd0, FN_SUBU);
            8: return r_type(R_A, R_B, R_C, 5'd0, FN_AND);
            9: return r_type(R_A, R_B, R_C, 5'd0, FN_OR);
            10: return r_type(R_A, R_B, R_C, 5'd0, FN_XOR);
            11: return r_type(R_A, R_B, R_C, 5'd0, FN_SLT);
            12: return r_type(R_A, R_B, R_C, 5'd0, FN_SLTU);
            13: return r_type(R_ZERO, R_B, R_C, sa, FN_SLL);
            14: return r_type(R_ZERO, R_B, R_C, sa, FN_SRL);
            default: return r_type(R_ZERO, R_B, R_C, sa, FN_SRA);
        endcase
    endfunction

    // MIPS result of each alu case, a in $8 and b in $9
    function automatic logic [31:0] reference_result(input int op, input logic [31:0] a,
                                                     input logic [31:0] b,
                                                     input logic [15:0] imm,
                                                     input logic [4:0] sa);
        logic [31:0] sext;
        logic [31:0] zext;
        sext = {{16{imm[15]}}, imm};
        zext = {16'h0000, imm};
        case (op)
            0: return a + sext;
            1: return {imm, 16'h0000};
            2: return a | zext;
            3: return a & zext;
            4: return a ^ zext;
            5: return {31'd0, $signed(a) < $signed(sext)};
            6: return a + b;
            7: return a - b;
            8: return a & b;
            9: return a | b;
            10: return a ^ b;
            11: return {31'd0, $signed(a) < $signed(b)};
            12: return {31'd0, a < b};
            13: return b << sa;
            14: return b >> sa;
            default: return $signed(b) >>> sa;
        endcase
    endfunction

    task automatic compare_word(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // program at 32'h20, then jr $0 and its delay slot
    task automatic load_program();
        for (int k = 0; k < 64; k++) begin
            imem[k] = 32'h0;
        end
        for (int k = 0; k < prog.size(); k++) begin
            imem[8 + k] = prog[k];
        end
        imem[8 + prog.size()] = r_type(R_ZERO, R_ZERO, R_ZERO, 5'd0, FN_JR);
        imem[9 + prog.size()] = 32'h0;
    endtask

    task automatic run_program(input logic stall);
        logic [31:0] r;
        load_program();
        @(posedge clk);
        reset <= 1'b1;
        clk_enable <= 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare_word("active after reset", {31'd0, active}, 32'd1);
        while (active) begin
            @(posedge clk);
            if (stall) begin
                r = random_bits(2);
                clk_enable <= r[1:0] != 2'b00;
            end else begin
                clk_enable <= 1'b1;
            end
            @(negedge clk);
        end
        compare_word("pc at halt", instr_address, 32'h0);
        @(posedge clk);
        clk_enable <= 1'b1;
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [31:0] value);
        prog.push_back(i_type(OPC_LUI, R_ZERO, rd, value[31:16]));
        prog.push_back(i_type(OPC_ORI, rd, rd, value[15:0]));
    endtask

    // sets one v0 bit, so v0 shows which instructions ran
    task automatic mark(input int bit_index, input logic runs);
        logic [15:0] m;
        m = 16'h0001 << bit_index;
        prog.push_back(i_type(OPC_ORI, R_V0, R_V0, m));
        if (runs) begin
            branch_expect = branch_expect | {16'h0000, m};
        end
    endtask

    task automatic reset_and_halt();
        prog.delete();
        run_program(1'b0);
        compare_word("v0 after empty program", register_v0, 32'h0);
    endtask

    task automatic alu_operations();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [15:0] imm;
        logic [4:0]  sa;
        for (int op = 0; op < 16; op++) begin
            a = random_bits(32);
            b = random_bits(32);
            r = random_bits(16);
            imm = r[15:0];
            r = random_bits(5);
            sa = r[4:0];
            prog.delete();
            load_word(R_A, a);
            load_word(R_B, b);
            prog.push_back(alu_instr(op, imm, sa));
            prog.push_back(r_type(R_C, R_ZERO, R_V0, 5'd0, FN_ADDU));
            run_program(1'b0);
            compare_word($sformatf("v0 after alu case %0d", op), register_v0,
                reference_result(op, a, b, imm, sa));
        end
    endtask

    task automatic memory_round_trip();
        logic [31:0] value;
        int          count_before;
        int          reads_before;
        value = random_bits(32);
        count_before = write_count;
        reads_before = read_count;
        prog.delete();
        load_word(R_A, value);
        prog.push_back(i_type(OPC_ADDIU, R_ZERO, R_B, 16'h0060));
        // negative offset checks the sign extension
        prog.push_back(i_type(OPC_SW, R_B, R_A, 16'hfff0));
        prog.push_back(i_type(OPC_LW, R_B, R_V0, 16'hfff0));
        run_program(1'b0);
        compare_word("store count", 32'(write_count - count_before), 32'd1);
        compare_word("store address", last_write_addr, 32'h60 - 32'd16);
        compare_word("store data", last_write_data, value);
        compare_word("data memory word", dmem[20], value);
        compare_word("load count", 32'(read_count - reads_before), 32'd1);
        compare_word("load address", last_read_addr, 32'h60 - 32'd16);
        compare_word("v0 after load", register_v0, value);
    endtask

    task automatic build_branch_program();
        logic [31:0] r;
        logic [31:0] target;
        r = random_bits(16);
        branch_expect = 32'h0;
        prog.delete();
        prog.push_back(i_type(OPC_ADDIU, R_ZERO, R_A, r[15:0]));
        prog.push_back(i_type(OPC_ADDIU, R_ZERO, R_B, r[15:0]));
        prog.push_back(i_type(OPC_ADDIU, R_A, R_C, 16'h0001));
        // each branch skips the word after its delay slot when taken
        prog.push_back(i_type(OPC_BEQ, R_A, R_B, 16'd2));
        mark(0, 1'b1);
        mark(1, 1'b0);
        mark(2, 1'b1);
        prog.push_back(i_type(OPC_BEQ, R_A, R_C, 16'd2));
        mark(3, 1'b1);
        mark(4, 1'b1);
        mark(5, 1'b1);
        prog.push_back(i_type(OPC_BNE, R_A, R_C, 16'd2));
        mark(6, 1'b1);
        mark(7, 1'b0);
        mark(8, 1'b1);
        prog.push_back(i_type(OPC_BNE, R_A, R_B, 16'd2));
        mark(9, 1'b1);
        mark(10, 1'b1);
        mark(11, 1'b1);
        target = 32'h20 + 32'(4 * (prog.size() + 3));
        prog.push_back({OPC_J, target[27:2]});
        mark(12, 1'b1);
        mark(13, 1'b0);
        mark(14, 1'b1);
        prog.push_back(i_type(OPC_SW, R_ZERO, R_V0, 16'h0044));
    endtask

    task automatic check_branch_result(input int count_before);
        compare_word("v0 after branches", register_v0, branch_expect);
        compare_word("branch store count", 32'(write_count - count_before), 32'd1);
        compare_word("branch store address", last_write_addr, 32'h44);
        compare_word("branch store data", last_write_data, branch_expect);
    endtask

    task automatic branch_delay_slots();
        int count_before;
        build_branch_program();
        count_before = write_count;
        run_program(1'b0);
        check_branch_result(count_before);
    endtask

    // same branch program, clk_enable low on about a quarter of the cycles
    task automatic stalled_rerun();
        int count_before;
        int stalls_before;
        count_before = write_count;
        stalls_before = stall_cycles;
        run_program(1'b1);
        check_branch_result(count_before);
        checks++;
        assert (stall_cycles > stalls_before) else begin
            errors++;
            $display("no stall cycle was applied during the stall run");
        end
    endtask

    initial begin
        reset = 1'b1;
        clk_enable = 1'b0;
        for (int k = 0; k < 64; k++) begin
            imem[k] = 32'h0;
            dmem[k] = 32'h5a00_0000 ^ (32'(k) * 32'h0104_0821);
        end
        reset_and_halt();
        alu_operations();
        memory_round_trip();
        branch_delay_slots();
        stalled_rerun();
        $display("checks: %0d, errors: %0d", checks + monitor_checks, errors + monitor_errors);
        if (errors + monitor_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/mips_isa_pkg.sv
src/mips_cpu_pkg.sv
src/control_fsm.sv
src/pc_counter.sv
src/reg_file.sv
src/exec_unit.sv
src/mips_cpu.sv
tb/tb_mips_cpu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_mips_cpu
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
